// File: flist.f
src/core_pkg.sv
src/pipe_reg.sv
src/fetch_unit.sv
src/decode.sv
src/regfile.sv
src/forwarding.sv
src/execute.sv
src/core.sv
bench/ibus_mem.sv
bench/core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the core testbench with Verilator, runs it and scans the log for the fail message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module core_tb -f flist.f -o core_tb_sim || exit 1
./obj_dir/core_tb_sim > sim.log 2>&1 ; cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || grep -q "RESULT: PASS" sim.log

// File: bench/core_tb.sv
`timescale 1ns/1ps

module core_tb;
	import core_pkg::*;

	localparam word_t reset_pc     = 64'h8000_0000;
	localparam int    num_instr    = 512;
	localparam int    num_tests    = 2;
	localparam int    clk_period   = 100;
	localparam int    reset_cycles = 8;
	localparam int    watchdog_ns  = num_tests * (num_instr * 5 + reset_cycles) * clk_period;
	localparam int    rng_seed     = 32'h6c2a_6369;

	logic        clk;
	logic        reset;
	logic        fixed_delay;
	ibus_req_t   ireq;
	ibus_resp_t  iresp;
	commit_t     commit;
	logic [31:0] prog [0:num_instr-1];
	word_t       model_regs [0:31];
	int          commit_count;
	int          since_reset;
	int          checked;
	int          errors;
	int          tests_run;

	core #(.RESET_PC(reset_pc)) dut_i (
		.clk(clk), .reset(reset), .ireq(ireq), .iresp(iresp), .commit(commit)
	);

	ibus_mem #(.base(reset_pc), .depth(num_instr)) mem_i (
		.clk(clk), .reset(reset), .fixed_delay(fixed_delay), .ireq(ireq), .iresp(iresp)
	);

	always #(clk_period / 2) clk = ~clk;

	// ##################################################
	// program generation and reference model.
	// ##################################################

	function automatic logic [2:0] pick_funct3();
		logic [2:0] f;
		case ($urandom_range(3, 0))
			0:       f = 3'b000;
			1:       f = 3'b100;
			2:       f = 3'b110;
			default: f = 3'b111;
		endcase
		return f;
	endfunction

	// registers come from x0 to x7 so that most instructions depend on recent ones.
	function automatic logic [31:0] random_instr();
		logic [31:0] w;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		int          kind;
		rd   = 5'($urandom_range(7, 0));
		rs1  = 5'($urandom_range(7, 0));
		rs2  = 5'($urandom_range(7, 0));
		kind = $urandom_range(99, 0);
		w    = $urandom;
		if (kind < 10) begin
			case ($urandom_range(2, 0))
				0:       w[6:0] = 7'h0b; // custom opcode.
				1:       w[14:0] = {3'b010, w[11:7], 7'h13}; // slti.
				default: w[31:25] = 7'h01; // multiply group.
			endcase
			if (w[6:0] != 7'h0b && w[31:25] == 7'h01) begin
				w[6:0] = 7'h33;
			end
		end else if (kind < 40) begin
			w = {w[31:20], rs1, pick_funct3(), rd, 7'h13};
		end else if (kind < 85) begin
			if (kind < 55) begin
				w = {7'h20, rs2, rs1, 3'b000, rd, 7'h33};
			end else begin
				w = {7'h00, rs2, rs1, pick_funct3(), rd, 7'h33};
			end
		end else begin
			w = {w[31:12], rd, 7'h37};
		end
		return w;
	endfunction

	task automatic model_step(input logic [31:0] instr, output logic wen,
		output creg_addr_t rd, output word_t result);
		word_t a;
		word_t b;
		word_t imm;
		logic  ok;
		a      = model_regs[instr[19:15]];
		b      = model_regs[instr[24:20]];
		imm    = {{52{instr[31]}}, instr[31:20]};
		rd     = instr[11:7];
		ok     = 1'b1;
		result = '0;
		if (instr[6:0] == 7'h13) begin
			case (instr[14:12])
				3'b000:  result = a + imm;
				3'b100:  result = a ^ imm;
				3'b110:  result = a | imm;
				3'b111:  result = a & imm;
				default: ok = 1'b0;
			endcase
		end else if (instr[6:0] == 7'h33 && instr[31:25] == 7'h00) begin
			case (instr[14:12])
				3'b000:  result = a + b;
				3'b100:  result = a ^ b;
				3'b110:  result = a | b;
				3'b111:  result = a & b;
				default: ok = 1'b0;
			endcase
		end else if (instr[6:0] == 7'h33 && instr[31:25] == 7'h20 && instr[14:12] == 3'b000) begin
			result = a - b;
		end else if (instr[6:0] == 7'h37) begin
			result = {{32{instr[31]}}, instr[31:12], 12'h000};
		end else begin
			ok = 1'b0;
		end
		wen = ok && rd != 5'd0;
		if (wen) begin
			model_regs[rd] = result;
		end
	endtask

	task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
		$display("Fail at %0d ns: %s expected %h, actual %h", $time, name, expected, actual);
		errors++;
	endtask

	// ##################################################
	// commit checking on the rising edge.
	// ##################################################

	always @(posedge clk) begin
		logic       exp_wen;
		creg_addr_t exp_rd;
		word_t      exp_data;
		word_t      exp_pc;
		if (ireq.valid != !reset) begin
			report_mismatch("ireq.valid", 64'(!reset), 64'(ireq.valid));
		end
		if (reset) begin
			if (commit.valid) begin
				$display("commit reported while reset was asserted at %0d ns", $time);
				errors++;
			end
			for (int r = 0; r < 32; r++) begin
				model_regs[r] = '0;
			end
			since_reset  = 0;
			commit_count = 0;
		end else begin
			if (commit.valid && since_reset < 4) begin
				$display("commit arrived only %0d cycles after reset", since_reset);
				errors++;
			end
			if (commit.valid && commit_count < num_instr) begin
				exp_pc = reset_pc + 64'(commit_count) * 64'd4;
				model_step(prog[commit_count], exp_wen, exp_rd, exp_data);
				if (commit.pc != exp_pc) begin
					report_mismatch("commit.pc", exp_pc, commit.pc);
				end
				if (commit.instr != prog[commit_count]) begin
					report_mismatch("commit.instr", 64'(prog[commit_count]), 64'(commit.instr));
				end
				if (commit.wen != exp_wen) begin
					report_mismatch("commit.wen", 64'(exp_wen), 64'(commit.wen));
				end
				if (exp_wen && commit.wdest != exp_rd) begin
					report_mismatch("commit.wdest", 64'(exp_rd), 64'(commit.wdest));
				end
				if (exp_wen && commit.wdata != exp_data) begin
					report_mismatch("commit.wdata", exp_data, commit.wdata);
				end
				commit_count++;
				checked++;
			end
			since_reset++;
		end
	end

	// ##################################################
	// test sequence and watchdog.
	// ##################################################

	task automatic run_test(input string name, input logic slow_bus);
		int errors_before;
		errors_before = errors;
		@(negedge clk);
		reset       = 1'b1;
		fixed_delay = slow_bus;
		repeat (reset_cycles) @(negedge clk);
		reset = 1'b0;
		wait (commit_count == num_instr);
		tests_run++;
		$display("test %s: %0d commits, %0d errors", name, commit_count, errors - errors_before);
	endtask

	initial begin
		clk          = 1'b0;
		reset        = 1'b1;
		fixed_delay  = 1'b0;
		checked      = 0;
		errors       = 0;
		tests_run    = 0;
		commit_count = 0;
		void'($urandom(rng_seed));
		for (int i = 0; i < num_instr; i++) begin
			prog[i]      = random_instr();
			mem_i.mem[i] = prog[i];
		end
		run_test("random bus delay", 1'b0);
		run_test("bus delay of 3 cycles", 1'b1);
		$display("tests %0d, commits checked %0d, errors %0d", tests_run, checked, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("timeout: commits stopped after %0d of %0d instructions in test %0d",
			commit_count, num_instr, tests_run + 1);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: bench/ibus_mem.sv
`timescale 1ns/1ps

module ibus_mem #(
	parameter core_pkg::word_t base  = 64'h8000_0000,
	parameter int              depth = 512
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 fixed_delay,
	input  core_pkg::ibus_req_t  ireq,
	output core_pkg::ibus_resp_t iresp
);
	import core_pkg::*;

	localparam int          idx_w = $clog2(depth);
	localparam logic [31:0] nop   = 32'h0000_0013; // addi x0, x0, 0 past the program.

	logic [31:0] mem [0:depth-1];
	logic [1:0]  wait_left;
	word_t       index;

	function automatic logic [1:0] pick_delay(input logic fixed);
		logic [1:0] d;
		if (fixed) begin
			d = 2'd3;
		end else begin
			d = 2'($urandom_range(3, 0));
		end
		return d;
	endfunction

	// a fresh delay is drawn for every request once the previous one is answered.
	always @(posedge clk) begin
		if (reset || iresp.data_ok) begin
			wait_left <= pick_delay(fixed_delay);
		end else if (wait_left != 2'd0) begin
			wait_left <= wait_left - 2'd1;
		end
	end

	assign index         = (ireq.addr - base) >> 2;
	assign iresp.data_ok = ireq.valid && wait_left == 2'd0;
	assign iresp.data    = (index < word_t'(depth)) ? mem[index[idx_w-1:0]] : nop;

endmodule

// File: src/core.sv
`timescale 1ns/1ps

module core #(
	parameter core_pkg::word_t RESET_PC = 64'h8000_0000
) (
	input  logic                 clk,
	input  logic                 reset,
	output core_pkg::ibus_req_t  ireq,
	input  core_pkg::ibus_resp_t iresp,
	output core_pkg::commit_t    commit
);
	import core_pkg::*;

	logic         stall;
	logic         wb_en;
	fetch_data_t  dataF_nxt, dataF;
	decode_data_t dataD_nxt, dataD;
	exec_data_t   dataE_nxt, dataE;
	exec_data_t   dataM;
	creg_addr_t   ra1, ra2;
	word_t        rd1, rd2;
	word_t        alusrca, alusrcb;
	fwd_data_t    ex_fwd, mem_fwd;

	assign stall = ireq.valid && !iresp.data_ok; // a pending fetch freezes every stage.
	assign wb_en = dataM.ctl.reg_write && !stall;

	fetch_unit #(
		.RESET_PC(RESET_PC)
	) fetch_unit_i (
		.clk  (clk),
		.reset(reset),
		.stall(stall),
		.ireq (ireq),
		.iresp(iresp),
		.data (dataF_nxt)
	);

	decode decode_i (
		.dataF(dataF),
		.ra1  (ra1),
		.ra2  (ra2),
		.rd1  (rd1),
		.rd2  (rd2),
		.dataD(dataD_nxt)
	);

	regfile regfile_i (
		.clk  (clk),
		.reset(reset),
		.wen  (wb_en),
		.wa   (dataM.dst),
		.wd   (dataM.aluout),
		.ra1  (ra1),
		.ra2  (ra2),
		.rd1  (rd1),
		.rd2  (rd2)
	);

	forwarding forwarding_i (
		.ex_fwd (ex_fwd),
		.mem_fwd(mem_fwd),
		.dataD  (dataD),
		.alusrca(alusrca),
		.alusrcb(alusrcb)
	);

	execute execute_i (
		.alusrca(alusrca),
		.alusrcb(alusrcb),
		.dataD  (dataD),
		.dataE  (dataE_nxt)
	);

	// ##################################################
	// the stage registers never flush because there are no branches.
	// ##################################################

	pipe_reg #(.payload_t(fetch_data_t)) if_id (
		.clk(clk), .reset(reset), .stall(stall), .flush(1'b0),
		.data_nxt(dataF_nxt), .data(dataF)
	);

	pipe_reg #(.payload_t(decode_data_t)) id_ex (
		.clk(clk), .reset(reset), .stall(stall), .flush(1'b0),
		.data_nxt(dataD_nxt), .data(dataD)
	);

	pipe_reg #(.payload_t(exec_data_t)) ex_mem (
		.clk(clk), .reset(reset), .stall(stall), .flush(1'b0),
		.data_nxt(dataE_nxt), .data(dataE)
	);

	// the memory stage has no work yet, so EX/MEM feeds MEM/WB directly.
	pipe_reg #(.payload_t(exec_data_t)) mem_wb (
		.clk(clk), .reset(reset), .stall(stall), .flush(1'b0),
		.data_nxt(dataE), .data(dataM)
	);

	// ##################################################
	// forwarding records and commit port.
	// ##################################################

	assign ex_fwd.dst     = dataE.dst;
	assign ex_fwd.data    = dataE.aluout;
	assign ex_fwd.enable  = dataE.ctl.reg_write;
	assign mem_fwd.dst    = dataM.dst;
	assign mem_fwd.data   = dataM.aluout;
	assign mem_fwd.enable = dataM.ctl.reg_write;

	// one report per retired instruction and none while reset is high.
	assign commit.valid = dataM.valid && !stall && !reset;
	assign commit.pc    = dataM.pc;
	assign commit.instr = dataM.raw_instr;
	assign commit.wen   = dataM.ctl.reg_write && dataM.dst != '0;
	assign commit.wdest = dataM.dst;
	assign commit.wdata = dataM.aluout;

endmodule

// File: src/execute.sv
`timescale 1ns/1ps

module execute (
	input  core_pkg::word_t        alusrca,
	input  core_pkg::word_t        alusrcb,
	input  core_pkg::decode_data_t dataD,
	output core_pkg::exec_data_t   dataE
);
	import core_pkg::*;

	word_t aluout;

	always_comb begin
		case (dataD.ctl.alu_op)
			alu_add:    aluout = alusrca + alusrcb;
			alu_sub:    aluout = alusrca - alusrcb;
			alu_and:    aluout = alusrca & alusrcb;
			alu_or:     aluout = alusrca | alusrcb;
			alu_xor:    aluout = alusrca ^ alusrcb;
			alu_pass_b: aluout = alusrcb; // LUI carries its result in the immediate.
			default:    aluout = '0;
		endcase
	end

	assign dataE.valid     = dataD.valid;
	assign dataE.pc        = dataD.pc;
	assign dataE.raw_instr = dataD.raw_instr;
	assign dataE.ctl       = dataD.ctl;
	assign dataE.dst       = dataD.dst;
	assign dataE.aluout    = aluout;

endmodule

// File: src/forwarding.sv
`timescale 1ns/1ps

module forwarding (
	input  core_pkg::fwd_data_t    ex_fwd,
	input  core_pkg::fwd_data_t    mem_fwd,
	input  core_pkg::decode_data_t dataD,
	output core_pkg::word_t        alusrca,
	output core_pkg::word_t        alusrcb
);
	import core_pkg::*;

	word_t fwd_b;

	// the younger result in EX/MEM wins over MEM/WB.
	function automatic word_t select_src(input creg_addr_t rs, input word_t regval,
		input fwd_data_t ex, input fwd_data_t mem);
		word_t val;
		if (ex.enable && ex.dst == rs && rs != '0) begin
			val = ex.data;
		end else if (mem.enable && mem.dst == rs && rs != '0) begin
			val = mem.data;
		end else begin
			val = regval;
		end
		return val;
	endfunction

	assign alusrca = select_src(dataD.rs1, dataD.srca, ex_fwd, mem_fwd);
	assign fwd_b   = select_src(dataD.rs2, dataD.srcb, ex_fwd, mem_fwd);
	assign alusrcb = dataD.ctl.is_imm ? dataD.imm : fwd_b;

endmodule

// File: src/regfile.sv
`timescale 1ns/1ps

module regfile (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 wen,
	input  core_pkg::creg_addr_t wa,
	input  core_pkg::word_t      wd,
	input  core_pkg::creg_addr_t ra1,
	input  core_pkg::creg_addr_t ra2,
	output core_pkg::word_t      rd1,
	output core_pkg::word_t      rd2
);
	import core_pkg::*;

	word_t regs [1:31]; // x0 has no storage.

	function automatic word_t read_port(input creg_addr_t ra);
		word_t val;
		if (ra == '0) begin
			val = '0;
		end else if (wen && ra == wa) begin
			val = wd; // write-through covers the instruction three ahead.
		end else begin
			val = regs[ra];
		end
		return val;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	always_comb begin
		rd1 = read_port(ra1);
		rd2 = read_port(ra2);
	end

endmodule

// File: src/decode.sv
`timescale 1ns/1ps

module decode (
	input  core_pkg::fetch_data_t  dataF,
	output core_pkg::creg_addr_t   ra1,
	output core_pkg::creg_addr_t   ra2,
	input  core_pkg::word_t        rd1,
	input  core_pkg::word_t        rd2,
	output core_pkg::decode_data_t dataD
);
	import core_pkg::*;

	logic [31:0] instr;
	logic [6:0]  opcode;
	logic [6:0]  funct7;
	logic [2:0]  funct3;
	word_t       imm_i;
	word_t       imm_u;
	ctl_t        ctl;
	logic        supported;

	assign instr  = dataF.raw_instr;
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign imm_i = {{52{instr[31]}}, instr[31:20]};
	assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0}; // RV64 sign-extends the LUI result.

	assign ra1 = instr[19:15];
	assign ra2 = instr[24:20];

	always_comb begin
		ctl       = '0;
		supported = 1'b0;
		case (opcode)
			op_imm: begin
				ctl.is_imm = 1'b1;
				supported  = 1'b1;
				case (funct3)
					3'b000:  ctl.alu_op = alu_add;
					3'b100:  ctl.alu_op = alu_xor;
					3'b110:  ctl.alu_op = alu_or;
					3'b111:  ctl.alu_op = alu_and;
					default: supported = 1'b0; // shifts and compares are not implemented.
				endcase
			end
			op_reg: begin
				supported = (funct7 == 7'b000_0000);
				case (funct3)
					3'b000: begin
						ctl.alu_op = funct7[5] ? alu_sub : alu_add;
						supported  = supported || (funct7 == 7'b010_0000);
					end
					3'b100:  ctl.alu_op = alu_xor;
					3'b110:  ctl.alu_op = alu_or;
					3'b111:  ctl.alu_op = alu_and;
					default: supported = 1'b0;
				endcase
			end
			op_lui: begin
				ctl.is_imm = 1'b1;
				ctl.alu_op = alu_pass_b;
				supported  = 1'b1;
			end
			default: supported = 1'b0;
		endcase
		ctl.reg_write = supported && dataF.valid; // anything else retires as a no-op.
	end

	assign dataD.valid     = dataF.valid;
	assign dataD.pc        = dataF.pc;
	assign dataD.raw_instr = instr;
	assign dataD.ctl       = ctl;
	assign dataD.dst       = instr[11:7];
	assign dataD.rs1       = ra1;
	assign dataD.rs2       = ra2;
	assign dataD.srca      = rd1;
	assign dataD.srcb      = rd2;
	assign dataD.imm       = (opcode == op_lui) ? imm_u : imm_i;

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
	parameter core_pkg::word_t RESET_PC = 64'h8000_0000
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  stall,
	output core_pkg::ibus_req_t   ireq,
	input  core_pkg::ibus_resp_t  iresp,
	output core_pkg::fetch_data_t data
);
	import core_pkg::*;

	word_t pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_PC;
		end else if (!stall) begin
			pc <= pc + 64'd4; // no branches, so the next PC is always sequential.
		end
	end

	assign ireq.valid = !reset;
	assign ireq.addr  = pc; // held until data_ok because the PC only moves without stall.

	assign data.valid     = iresp.data_ok;
	assign data.pc        = pc;
	assign data.raw_instr = iresp.data;

endmodule

// File: src/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     stall,
	input  logic     flush,
	input  payload_t data_nxt,
	output payload_t data
);

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			data <= '0; // a zero payload is a bubble, valid is low.
		end else if (!stall) begin
			data <= data_nxt;
		end
	end

endmodule

// File: src/core_pkg.sv
package core_pkg;

	// ##################################################
	// widths and basic types.
	// ##################################################

	parameter int xlen = 64;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0]      creg_addr_t;

	parameter logic [6:0] op_imm = 7'b001_0011; // ADDI, XORI, ORI, ANDI.
	parameter logic [6:0] op_reg = 7'b011_0011; // ADD, SUB, AND, OR, XOR.
	parameter logic [6:0] op_lui = 7'b011_0111;

	typedef struct packed {
		logic  valid;
		word_t addr;
	} ibus_req_t;

	typedef struct packed {
		logic        data_ok;
		logic [31:0] data;
	} ibus_resp_t;

	// ##################################################
	// control and stage payloads.
	// ##################################################

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b
	} alu_op_t;

	typedef struct packed {
		logic    reg_write;
		logic    is_imm;
		alu_op_t alu_op;
	} ctl_t;

	typedef struct packed {
		logic        valid;
		word_t       pc;
		logic [31:0] raw_instr;
	} fetch_data_t;

	typedef struct packed {
		logic        valid;
		word_t       pc;
		logic [31:0] raw_instr;
		ctl_t        ctl;
		creg_addr_t  dst;
		creg_addr_t  rs1;
		creg_addr_t  rs2;
		word_t       srca;
		word_t       srcb;
		word_t       imm;
	} decode_data_t;

	// the memory stage reuses this payload unchanged.
	typedef struct packed {
		logic        valid;
		word_t       pc;
		logic [31:0] raw_instr;
		ctl_t        ctl;
		creg_addr_t  dst;
		word_t       aluout;
	} exec_data_t;

	typedef struct packed {
		creg_addr_t dst;
		word_t      data;
		logic       enable;
	} fwd_data_t;

	typedef struct packed {
		logic        valid;
		word_t       pc;
		logic [31:0] instr;
		logic        wen;
		creg_addr_t  wdest;
		word_t       wdata;
	} commit_t;

endpackage
